// File: Makefile
# Verilator build and run of the execution cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_exec_cluster
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Test completed successfully

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
HDRS := $(wildcard source/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+source
source/exec_pkg.sv
source/credit_queue.sv
source/op_dispatch.sv
source/alu_pipe.sv
source/div_unit.sv
source/wb_merge.sv
source/exec_cluster.sv
test/tb_exec_cluster.sv

// File: source/alu_pipe.sv
////////////////////
// Two-stage integer ALU, sends only while it holds a result credit
////////////////////
`include "exec_settings.svh"

module alu_pipe (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  exec_pkg::issue_t  op,
	output logic              ready,
	output logic              res_valid,
	output exec_pkg::result_t res,
	input  logic              res_credit
);
	import exec_pkg::*;

	localparam int CNT_W = $clog2(`RES_DEPTH + 1);
	localparam int SH_W  = $clog2(`XLEN);

	logic [`XLEN-1:0] alu_val;
	logic [SH_W-1:0]  shamt;
	logic             s1_valid;
	result_t          s1_res;
	logic [CNT_W-1:0] credits;   // Free slots in the merger's ALU queue

	assign shamt = op.op_b[SH_W-1:0];

	always_comb begin
		case (op.alu_op)
			ALU_ADD:  alu_val = op.op_a + op.op_b;
			ALU_SUB:  alu_val = op.op_a - op.op_b;
			ALU_AND:  alu_val = op.op_a & op.op_b;
			ALU_OR:   alu_val = op.op_a | op.op_b;
			ALU_XOR:  alu_val = op.op_a ^ op.op_b;
			ALU_SLL:  alu_val = op.op_a << shamt;
			ALU_SRL:  alu_val = op.op_a >> shamt;
			ALU_SRA:  alu_val = $unsigned($signed(op.op_a) >>> shamt);
			ALU_SLT:  alu_val = `XLEN'($signed(op.op_a) < $signed(op.op_b));
			ALU_SLTU: alu_val = `XLEN'(op.op_a < op.op_b);
			default:  alu_val = '0;
		endcase
	end

	// An op arriving now already holds one of the counted credits
	assign ready = (credits > CNT_W'(in_valid));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			res_valid <= 1'b0;
			credits   <= CNT_W'(`RES_DEPTH);
		end else begin
			s1_valid  <= in_valid;
			res_valid <= s1_valid;
			credits   <= credits - CNT_W'(in_valid) + CNT_W'(res_credit);
		end
	end

	always_ff @(posedge clk) begin
		s1_res <= '{tag: op.tag, value: alu_val};   // Stage one
		res    <= s1_res;                           // Stage two
	end

	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= CNT_W'(`RES_DEPTH));

endmodule

// File: source/credit_queue.sv
////////////////////
// FIFO for any payload type that pulses one credit back per entry popped
////////////////////
module credit_queue #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output logic     head_valid,
	output payload_t head_data,
	output logic     credit
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];   // Entry storage
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;
	logic             full;

	assign head_valid = (count != '0);
	assign full       = (count == CNT_W'(DEPTH));
	assign head_data  = mem[rd_ptr];      // Show-ahead read
	assign do_pop     = pop && head_valid; // Pop on empty ignored

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count  <= count + CNT_W'(push) - CNT_W'(do_pop);
			credit <= do_pop;   // One pulse per freed slot
		end
	end

	// Sender must hold a credit for every push
	a_push_not_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);

endmodule

// File: source/div_unit.sv
////////////////////
// Radix-2 restoring divider, one divide in flight until its result is credited
////////////////////
`include "exec_settings.svh"

module div_unit (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  exec_pkg::issue_t  op,
	output logic              ready,
	output logic              res_valid,
	output exec_pkg::result_t res,
	input  logic              res_credit
);
	import exec_pkg::*;

	localparam int STEP_W = $clog2(`DIV_STEPS);

	typedef enum logic [1:0] {S_IDLE, S_RUN, S_FIX, S_WAIT} state_e;

	state_e            state;
	logic [STEP_W-1:0] step;
	logic [`XLEN-1:0]  quo;       // Dividend shifts out, quotient shifts in
	logic [`XLEN-1:0]  rem;       // Partial remainder
	logic [`XLEN-1:0]  dvs;       // Divisor magnitude
	logic [`TAG_W-1:0] tag;
	logic              want_rem;
	logic              q_neg;
	logic              r_neg;
	logic              signed_op;
	logic              a_neg;
	logic              b_neg;
	logic [`XLEN-1:0]  abs_a;
	logic [`XLEN-1:0]  abs_b;
	logic [`XLEN:0]    shifted;
	logic [`XLEN:0]    diff;

	assign signed_op = (op.div_op == DIV_DIV) || (op.div_op == DIV_REM);
	assign a_neg     = signed_op && op.op_a[`XLEN-1];
	assign b_neg     = signed_op && op.op_b[`XLEN-1];
	assign abs_a     = a_neg ? -op.op_a : op.op_a;
	assign abs_b     = b_neg ? -op.op_b : op.op_b;

	// Trial subtract, bit XLEN set means restore
	assign shifted = {rem, quo[`XLEN-1]};
	assign diff    = shifted - {1'b0, dvs};

	// Free only when idle and nothing arriving this cycle
	assign ready = (state == S_IDLE) && !in_valid;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			step      <= '0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= 1'b0;
			case (state)
				S_IDLE: if (in_valid) begin
					if (op.op_b == '0) begin  // Divide by zero, answer next cycle
						res_valid <= 1'b1;
						state     <= S_WAIT;
					end else begin
						step  <= '0;
						state <= S_RUN;
					end
				end
				S_RUN: begin
					step <= step + 1'b1;
					if (step == STEP_W'(`DIV_STEPS - 1)) state <= S_FIX;
				end
				S_FIX: begin
					res_valid <= 1'b1;
					state     <= S_WAIT;
				end
				S_WAIT: if (res_credit) state <= S_IDLE;   // Merger popped it
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: if (in_valid) begin
				quo      <= abs_a;
				rem      <= '0;
				dvs      <= abs_b;
				tag      <= op.tag;
				want_rem <= op.div_op[1];
				q_neg    <= a_neg ^ b_neg;
				r_neg    <= a_neg;       // Remainder takes the dividend's sign
				res.tag  <= op.tag;
				// All ones quotient, dividend as remainder
				res.value <= op.div_op[1] ? op.op_a : '1;
			end
			S_RUN: begin
				rem <= diff[`XLEN] ? shifted[`XLEN-1:0] : diff[`XLEN-1:0];
				quo <= {quo[`XLEN-2:0], !diff[`XLEN]};
			end
			// Most negative over -1 lands back on the dividend, rem 0
			S_FIX: begin
				res.tag   <= tag;
				res.value <= want_rem ? (r_neg ? -rem : rem) : (q_neg ? -quo : quo);
			end
			default: ;
		endcase
	end

	// Dispatcher must see ready low until the credit returns
	a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> state == S_IDLE);

endmodule

// File: source/exec_cluster.sv
////////////////////
// Execution cluster top, credited issue in and credited results out
////////////////////
`include "exec_settings.svh"

module exec_cluster (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  exec_pkg::issue_t  in_op,
	output logic              in_credit,
	output logic              out_valid,
	output exec_pkg::result_t out_res,
	input  logic              out_credit
);
	import exec_pkg::*;

	logic    iq_valid, iq_pop;
	issue_t  iq_op;
	issue_t  disp_op;             // Shared by both units
	logic    alu_ready, div_ready;
	logic    alu_go, div_go;
	logic    alu_res_valid, div_res_valid;
	logic    alu_res_credit, div_res_credit;
	result_t alu_res, div_res;

	credit_queue #(.payload_t(issue_t), .DEPTH(`ISSUE_DEPTH)) u_issue_q (
		.clk(clk), .rst_n(rst_n),
		.push(in_valid), .push_data(in_op),
		.pop(iq_pop), .head_valid(iq_valid), .head_data(iq_op),
		.credit(in_credit)           // Back to the sender
	);

	op_dispatch u_dispatch (
		.clk(clk), .rst_n(rst_n),
		.head_valid(iq_valid), .head_op(iq_op), .pop(iq_pop),
		.alu_ready(alu_ready), .div_ready(div_ready),
		.alu_valid(alu_go), .div_valid(div_go), .op(disp_op)
	);

	alu_pipe u_alu (
		.clk(clk), .rst_n(rst_n),
		.in_valid(alu_go), .op(disp_op), .ready(alu_ready),
		.res_valid(alu_res_valid), .res(alu_res), .res_credit(alu_res_credit)
	);

	div_unit u_div (
		.clk(clk), .rst_n(rst_n),
		.in_valid(div_go), .op(disp_op), .ready(div_ready),
		.res_valid(div_res_valid), .res(div_res), .res_credit(div_res_credit)
	);

	wb_merge u_merge (
		.clk(clk), .rst_n(rst_n),
		.alu_valid(alu_res_valid), .alu_res(alu_res), .alu_credit(alu_res_credit),
		.div_valid(div_res_valid), .div_res(div_res), .div_credit(div_res_credit),
		.out_valid(out_valid), .out_res(out_res), .out_credit(out_credit)
	);

endmodule

// File: source/exec_pkg.sv
////////////////////
// Operation encodings and packed payloads shared across the cluster
////////////////////
`include "exec_settings.svh"

package exec_pkg;

	// Target unit
	typedef enum logic {
		KIND_ALU = 1'b0,
		KIND_DIV = 1'b1
	} op_kind_e;

	// ALU operations
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SLTU = 4'd9
	} alu_op_e;

	// Bit 0 set for unsigned, bit 1 set for remainder
	typedef enum logic [1:0] {
		DIV_DIV  = 2'b00,
		DIV_DIVU = 2'b01,
		DIV_REM  = 2'b10,
		DIV_REMU = 2'b11
	} div_op_e;

	typedef struct packed {
		logic [`TAG_W-1:0] tag;   // Returned with the result
		op_kind_e          kind;
		alu_op_e           alu_op;  // Ignored for divides
		div_op_e           div_op;  // Ignored for ALU ops
		logic [`XLEN-1:0]  op_a;
		logic [`XLEN-1:0]  op_b;
	} issue_t;

	typedef struct packed {
		logic [`TAG_W-1:0] tag;
		logic [`XLEN-1:0]  value;
	} result_t;

endpackage

// File: source/exec_settings.svh
////////////////////
// Sizing macros for the execution cluster, included by the package and the RTL
////////////////////
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

`define XLEN        32      // Operand width
`define TAG_W       6       // Result tag width
`define ISSUE_DEPTH 4       // Issue queue slots, also input credits
`define RES_DEPTH   4       // Slots per result queue in the merger
`define OUT_CREDITS 4       // Credits toward the consumer after reset

// One quotient bit per iteration
`define DIV_STEPS   `XLEN

`endif

// File: source/op_dispatch.sv
////////////////////
// Steers the issue queue head to the ALU or the divider
////////////////////
module op_dispatch (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             head_valid,
	input  exec_pkg::issue_t head_op,
	output logic             pop,
	input  logic             alu_ready,
	input  logic             div_ready,
	output logic             alu_valid,
	output logic             div_valid,
	output exec_pkg::issue_t op
);
	import exec_pkg::*;

	logic is_div;

	assign is_div = (head_op.kind == KIND_DIV);

	// Head waits in the queue until its own unit grants
	assign pop = head_valid && (is_div ? div_ready : alu_ready);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			alu_valid <= 1'b0;
			div_valid <= 1'b0;
		end else begin
			alu_valid <= pop && !is_div;
			div_valid <= pop && is_div;
		end
	end

	// Shared operation register, both units see the same payload
	always_ff @(posedge clk) begin
		if (pop) op <= head_op;
	end

endmodule

// File: source/wb_merge.sv
////////////////////
// Merges ALU and divider results into one credited output stream
////////////////////
`include "exec_settings.svh"

module wb_merge (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              alu_valid,
	input  exec_pkg::result_t alu_res,
	output logic              alu_credit,
	input  logic              div_valid,
	input  exec_pkg::result_t div_res,
	output logic              div_credit,
	output logic              out_valid,
	output exec_pkg::result_t out_res,
	input  logic              out_credit
);
	import exec_pkg::*;

	localparam int CNT_W = $clog2(`OUT_CREDITS + 1);

	logic             alu_hv, div_hv;
	logic             alu_pop, div_pop;
	result_t          alu_head, div_head;
	logic             fire;
	logic             pick_alu;
	logic             last_alu;   // Round-robin pointer
	logic [CNT_W-1:0] credits;    // Consumer slots left

	credit_queue #(.payload_t(result_t), .DEPTH(`RES_DEPTH)) u_alu_q (
		.clk(clk), .rst_n(rst_n),
		.push(alu_valid), .push_data(alu_res),
		.pop(alu_pop), .head_valid(alu_hv), .head_data(alu_head),
		.credit(alu_credit)
	);

	credit_queue #(.payload_t(result_t), .DEPTH(`RES_DEPTH)) u_div_q (
		.clk(clk), .rst_n(rst_n),
		.push(div_valid), .push_data(div_res),
		.pop(div_pop), .head_valid(div_hv), .head_data(div_head),
		.credit(div_credit)
	);

	assign fire     = (credits != '0) && (alu_hv || div_hv);
	assign pick_alu = alu_hv && (!div_hv || !last_alu);  // Alternate when both wait
	assign alu_pop  = fire && pick_alu;
	assign div_pop  = fire && !pick_alu;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			last_alu  <= 1'b0;
			credits   <= CNT_W'(`OUT_CREDITS);
		end else begin
			out_valid <= fire;
			if (fire) last_alu <= pick_alu;
			credits <= credits - CNT_W'(fire) + CNT_W'(out_credit);
		end
	end

	always_ff @(posedge clk) begin
		if (fire) out_res <= pick_alu ? alu_head : div_head;
	end

	// Consumer never returns more than it was sent
	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= CNT_W'(`OUT_CREDITS));

endmodule

// File: test/tb_exec_cluster.sv
////////////////////
// Random credited traffic through the execution cluster checked against a tag model
////////////////////
`include "exec_settings.svh"

module tb_exec_cluster;
	timeunit 1ns;
	timeprecision 100ps;

	import exec_pkg::*;

	localparam int N_OPS  = 300;
	localparam int N_TAGS = 1 << `TAG_W;
	localparam logic [`XLEN-1:0] MIN_NEG = {1'b1, {(`XLEN-1){1'b0}}};

	logic    clk;
	logic    rst_n;
	logic    in_valid;
	issue_t  in_op;
	logic    in_credit;
	logic    out_valid;
	result_t out_res;
	logic    out_credit;

	logic [31:0]       rng;                 // xorshift state
	logic [`XLEN-1:0]  expected [N_TAGS];   // Model value per tag
	logic              pending [N_TAGS];    // Tag issued, result not back yet
	logic              on_div [N_TAGS];
	logic [`TAG_W-1:0] alu_order [$];       // Issue order per unit
	logic [`TAG_W-1:0] div_order [$];
	int                sent, received, credit_pulses;
	int                in_credits;          // Our credits toward the issue queue
	int                dut_credits;         // DUT's credits toward us
	int                held;                // Slots freed but not yet returned
	int                hold_off;            // Consumer stall countdown
	int                value_errs, proto_errs;
	bit                timed_out;

	exec_cluster u_dut (
		.clk(clk), .rst_n(rst_n),
		.in_valid(in_valid), .in_op(in_op), .in_credit(in_credit),
		.out_valid(out_valid), .out_res(out_res), .out_credit(out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			value_errs++;
			$display("** Error %s at %0t: expected %h, actual %h", name, $time, exp, act);
		end
	endtask

	// Reference results by the RISC-V integer rules
	function automatic logic [`XLEN-1:0] model_value(input issue_t op);
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b;
		logic [4:0]       sh;
		logic             ovf;
		a   = op.op_a;
		b   = op.op_b;
		sh  = b[4:0];
		ovf = (a == MIN_NEG) && (b == '1);   // Signed overflow pair
		if (op.kind == KIND_ALU) begin
			case (op.alu_op)
				ALU_ADD:  return a + b;
				ALU_SUB:  return a - b;
				ALU_AND:  return a & b;
				ALU_OR:   return a | b;
				ALU_XOR:  return a ^ b;
				ALU_SLL:  return a << sh;
				ALU_SRL:  return a >> sh;
				ALU_SRA:  return a[`XLEN-1] ? ~(~a >> sh) : a >> sh;      // Sign fill
				ALU_SLT:  return `XLEN'((a ^ MIN_NEG) < (b ^ MIN_NEG));  // Offset binary
				ALU_SLTU: return `XLEN'(a < b);
				default:  return '0;
			endcase
		end
		// Divide by zero
		if (b == '0) return (op.div_op == DIV_REM || op.div_op == DIV_REMU) ? a : '1;
		case (op.div_op)
			DIV_DIVU: return a / b;
			DIV_REMU: return a % b;
			DIV_DIV:  return ovf ? a : $unsigned($signed(a) / $signed(b));
			default:  return ovf ? '0 : $unsigned($signed(a) % $signed(b));
		endcase
	endfunction

	function automatic issue_t make_op(input logic [`TAG_W-1:0] tag);
		issue_t      op;
		logic [31:0] r;
		r         = xorshift32();
		op.tag    = tag;
		op.kind   = (r[2:0] < 3'd3) ? KIND_DIV : KIND_ALU;   // About 3 in 8 divide
		op.alu_op = alu_op_e'(4'(r[7:4] % 4'd10));
		op.div_op = div_op_e'(r[9:8]);
		op.op_a   = xorshift32();
		op.op_b   = xorshift32() >> r[14:10];   // Spread divisor sizes
		if (r[23]) op.op_b = -op.op_b;
		case (r[17:15])
			3'd0: op.op_b = '0;   // Forced zero divisor
			3'd1: begin           // Forced overflow pair
				op.op_a = MIN_NEG;
				op.op_b = '1;
			end
			3'd2: op.op_a = op.op_a >> r[22:18];
			default: ;
		endcase
		return op;
	endfunction

	task automatic take_result(input result_t res);
		logic [`TAG_W-1:0] want;
		if (dut_credits <= 0) begin
			proto_errs++;
			$display("out_valid fired at %0t while the DUT held no output credit", $time);
		end else begin
			dut_credits--;
		end
		held++;
		if (!pending[res.tag]) begin
			proto_errs++;
			$display("Result with tag %0d at %0t was not outstanding", res.tag, $time);
		end else begin
			pending[res.tag] = 1'b0;
			received++;
			if (on_div[res.tag]) begin
				want = div_order.pop_front();
				check_value("divide order", 32'(want), 32'(res.tag));
				check_value("divide value", expected[res.tag], res.value);
			end else begin
				want = alu_order.pop_front();
				check_value("alu order", 32'(want), 32'(res.tag));
				check_value("alu value", expected[res.tag], res.value);
			end
		end
	endtask

	// One clock that samples outputs of the last edge and then drives the next inputs
	task automatic run_cycle(input bit may_send);
		issue_t      op;
		logic [31:0] r;
		@(posedge clk);
		if (in_credit) begin
			in_credits++;
			credit_pulses++;
		end
		if (out_valid) take_result(out_res);
		r = xorshift32();
		out_credit <= 1'b0;
		if (hold_off > 0) hold_off--;
		else if (r[5:0] == 6'd0) hold_off = 20 + int'(r[11:6]);   // Long stall backs up the pipe
		else if (held > 0 && r[13:12] != 2'd0) begin
			out_credit <= 1'b1;
			held--;
			dut_credits++;
		end
		in_valid <= 1'b0;
		// Under 60 outstanding keeps tags unique
		if (may_send && in_credits > 0 && sent - received < 60 && r[15:14] != 2'd0) begin
			op = make_op(`TAG_W'(sent));
			in_valid <= 1'b1;
			in_op    <= op;
			in_credits--;
			sent++;
			expected[op.tag] = model_value(op);
			pending[op.tag]  = 1'b1;
			on_div[op.tag]   = (op.kind == KIND_DIV);
			if (op.kind == KIND_DIV) div_order.push_back(op.tag);
			else alu_order.push_back(op.tag);
		end
	endtask

	initial begin
		int wait_cycles;
		rng        = 32'h54fe_2321;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_op      = '0;
		out_credit = 1'b0;
		sent = 0;
		received = 0;
		credit_pulses = 0;
		in_credits  = `ISSUE_DEPTH;
		dut_credits = `OUT_CREDITS;
		held = 0;
		hold_off = 0;
		value_errs = 0;
		proto_errs = 0;
		timed_out  = 1'b0;
		for (int i = 0; i < N_TAGS; i++) pending[i] = 1'b0;

		repeat (16) @(posedge clk);
		check_value("in_credit in reset", 0, 32'(in_credit));
		check_value("out_valid in reset", 0, 32'(out_valid));
		rst_n <= 1'b1;

		wait_cycles = 0;
		while (sent < N_OPS && !timed_out) begin
			run_cycle(1'b1);
			wait_cycles++;
			if (wait_cycles > 40000) begin
				timed_out = 1'b1;
				$display("Timeout: only %0d of %0d operations were accepted", sent, N_OPS);
			end
		end

		// Drain while credits keep flowing back
		wait_cycles = 0;
		while ((received < N_OPS || credit_pulses < N_OPS) && !timed_out) begin
			run_cycle(1'b0);
			wait_cycles++;
			if (wait_cycles > 5000) begin
				timed_out = 1'b1;
				$display("Timeout: drain stopped with %0d results and %0d input credits back",
					received, credit_pulses);
			end
		end

		check_value("input credit pulses", N_OPS, credit_pulses);
		$display("Value errors: %0d, protocol errors: %0d", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0 && !timed_out) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
